//--- hdl/rdp_phy_pkg.sv
// ************************************************
// Read datapath PHY package
// Memory and AFI widths, data types and the AFI
// read request struct of the half rate DDR3 PHY
// ************************************************

`default_nettype none

package rdp_phy_pkg;

	// Memory side geometry
	localparam int NUM_DQS_GROUPS   = 2;
	localparam int DQ_GROUP_WIDTH   = 8;
	localparam int MEM_DQ_WIDTH     = NUM_DQS_GROUPS * DQ_GROUP_WIDTH;

	// Half rate interface, two AFI phases of two DDR beats each
	localparam int AFI_RATE_RATIO   = 2;
	localparam int NUM_TIMESLOTS    = 2 * AFI_RATE_RATIO;
	localparam int AFI_DATA_WIDTH   = MEM_DQ_WIDTH * NUM_TIMESLOTS;
	localparam int GROUP_DATA_WIDTH = DQ_GROUP_WIDTH * NUM_TIMESLOTS;

	// Read FIFO geometry, one FIFO per DQS group
	localparam int READ_FIFO_DEPTH     = 8;
	localparam int READ_FIFO_PTR_WIDTH = $clog2(READ_FIFO_DEPTH);
	// Count needs one more bit to tell full from empty
	localparam int READ_FIFO_CNT_WIDTH = READ_FIFO_PTR_WIDTH + 1;

	// One beat of one DQS group
	typedef logic [DQ_GROUP_WIDTH-1:0]      dq_group_t;
	// One DQS group's four beats of an AFI cycle, slot 0 in the low bits
	typedef logic [GROUP_DATA_WIDTH-1:0]    group_data_t;
	typedef logic [AFI_DATA_WIDTH-1:0]      afi_data_t;
	typedef logic [AFI_RATE_RATIO-1:0]      afi_phase_t;
	typedef logic [NUM_DQS_GROUPS-1:0]      group_mask_t;
	typedef logic [READ_FIFO_PTR_WIDTH-1:0] fifo_ptr_t;
	typedef logic [READ_FIFO_CNT_WIDTH-1:0] fifo_cnt_t;

	// ************************************************
	// Read request from the controller
	// ************************************************
	// The controller raises both vectors together for every read
	// Only phase 0 of each one is used by the datapath
	typedef struct packed {
		afi_phase_t rdata_en;
		afi_phase_t rdata_en_full;
	} afi_rd_req_t;

endpackage

`default_nettype wire

//--- hdl/rdp_cfg_pkg.sv
// ************************************************
// Read datapath configuration package
// Register map, latency type, OCT delays and the
// APB request and response structs
// ************************************************

`default_nettype none

package rdp_cfg_pkg;

	// Depth of the read latency shift registers
	localparam int MAX_READ_LATENCY = 16;
	typedef logic [$clog2(MAX_READ_LATENCY)-1:0] latency_t;

	// OCT window, in AFI cycles, derived from the memory read latency
	localparam int MEM_T_RL      = 11;
	localparam int OCT_ON_DELAY  = (MEM_T_RL - 4) / 2;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	typedef logic [3:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Register map of the sequencer control block
	localparam apb_addr_t ADDR_LAT      = 4'h0;
	localparam apb_addr_t ADDR_FIFO_RST = 4'h4;
	localparam apb_addr_t ADDR_STATUS   = 4'h8;
	localparam latency_t  LAT_RESET     = 4'd4;

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

	typedef enum logic [0:0] {IDLE, ACCESS} rdp_state_e;

endpackage

`default_nettype wire

//--- hdl/rdp_seq_regs.sv
// ************************************************
// Sequencer register block
// APB slave with the read latency, the per-group
// FIFO reset and the sticky overflow status
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module rdp_seq_regs (
	input  wire                       pll_afi_clk,
	input  wire                       reset_n_afi_clk,
	input  wire rdp_cfg_pkg::apb_req_t   apb_req_i,
	output rdp_cfg_pkg::apb_rsp_t        apb_rsp_o,
	input  wire rdp_phy_pkg::group_mask_t overflow_i,
	output rdp_cfg_pkg::latency_t        latency_o,
	output rdp_phy_pkg::group_mask_t     fifo_rst_o
);

	import rdp_phy_pkg::*;
	import rdp_cfg_pkg::*;

	rdp_state_e state;
	rdp_state_e state_nxt;
	logic       access;
	logic       mapped;
	apb_data_t  rd_data;

	// Setup phase moves to ACCESS, the access phase always completes in one cycle
	always_comb
	begin
		state_nxt = IDLE;
		if (state == IDLE && apb_req_i.psel && !apb_req_i.penable)
			state_nxt = ACCESS;
	end

	assign access = (state == ACCESS) && apb_req_i.psel && apb_req_i.penable;
	assign mapped = (apb_req_i.paddr == ADDR_LAT) || (apb_req_i.paddr == ADDR_FIFO_RST) ||
		(apb_req_i.paddr == ADDR_STATUS);

	// Read mux, the status bits come straight from the FIFOs
	always_comb
	begin
		case (apb_req_i.paddr)
			ADDR_LAT:      rd_data = apb_data_t'(latency_o);
			ADDR_FIFO_RST: rd_data = apb_data_t'(fifo_rst_o);
			ADDR_STATUS:   rd_data = apb_data_t'(overflow_i);
			default:       rd_data = '0;
		endcase
	end

	// No wait states, so pready follows the access phase
	assign apb_rsp_o.pready  = (state == ACCESS);
	assign apb_rsp_o.prdata  = access ? rd_data : '0;
	// STATUS is read only, writing it is an error just like a hole in the map
	assign apb_rsp_o.pslverr = access && (!mapped ||
		(apb_req_i.pwrite && apb_req_i.paddr == ADDR_STATUS));

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			state      <= IDLE;
			latency_o  <= LAT_RESET;
			fifo_rst_o <= '0;
		end
		else
		begin
			state <= state_nxt;
			// Writes land at the end of the access phase
			if (access && apb_req_i.pwrite)
			begin
				if (apb_req_i.paddr == ADDR_LAT)
					// Zero latency is not supported and is bumped to one
					latency_o <= (apb_req_i.pwdata[3:0] == '0) ? latency_t'(1) :
						apb_req_i.pwdata[3:0];
				if (apb_req_i.paddr == ADDR_FIFO_RST)
					fifo_rst_o <= apb_req_i.pwdata[NUM_DQS_GROUPS-1:0];
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/rdp_latency_shifter.sv
// ************************************************
// Read latency shifter
// Delays the read enables by the programmed latency
// and produces the FIFO pop and AFI read valid
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module rdp_latency_shifter (
	input  wire                           pll_afi_clk,
	input  wire                           reset_n_afi_clk,
	input  wire rdp_phy_pkg::afi_rd_req_t afi_rd_req_i,
	input  wire rdp_cfg_pkg::latency_t    latency_i,
	output logic                          read_enable_o,
	output rdp_phy_pkg::afi_phase_t       afi_rdata_valid_o
);

	import rdp_phy_pkg::*;
	import rdp_cfg_pkg::*;

	// Bit 0 holds the enable sampled at the last edge, bit k the one k edges earlier
	logic [MAX_READ_LATENCY-1:0] valid_sr;
	logic [MAX_READ_LATENCY-1:0] full_sr;
	logic                        valid_r;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			valid_sr <= '0;
			full_sr  <= '0;
			valid_r  <= 1'b0;
		end
		else
		begin
			valid_sr <= {valid_sr[MAX_READ_LATENCY-2:0], afi_rd_req_i.rdata_en[0]};
			full_sr  <= {full_sr[MAX_READ_LATENCY-2:0], afi_rd_req_i.rdata_en_full[0]};
			// One extra stage lines valid up with the registered FIFO output
			valid_r  <= valid_sr[latency_i];
		end
	end

	// Pop is high in the cycle after edge L, data appears at edge L+1
	assign read_enable_o = full_sr[latency_i];

	// Both AFI phases carry the same valid
	assign afi_rdata_valid_o = {AFI_RATE_RATIO{valid_r}};

endmodule

`default_nettype wire

//--- hdl/rdp_read_fifo.sv
// ************************************************
// Read FIFO for one DQS group
// Stores captured read words until the delayed read
// enable pops them, and flags overflow
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module rdp_read_fifo (
	input  wire                           pll_afi_clk,
	input  wire                           reset_n_afi_clk,
	input  wire                           fifo_rst_i,
	input  wire                           wr_en_i,
	input  wire rdp_phy_pkg::group_data_t wr_data_i,
	input  wire                           rd_en_i,
	output rdp_phy_pkg::group_data_t      rd_data_o,
	output logic                          overflow_o
);

	import rdp_phy_pkg::*;

	group_data_t mem [READ_FIFO_DEPTH];
	fifo_ptr_t   wr_ptr;
	fifo_ptr_t   rd_ptr;
	fifo_cnt_t   count;
	logic        full;
	logic        empty;
	logic        push;
	logic        pop;

	assign full  = (count == fifo_cnt_t'(READ_FIFO_DEPTH));
	assign empty = (count == '0);
	// A word arriving on a full FIFO is dropped
	assign push  = wr_en_i && !full && !fifo_rst_i;
	// Popping an empty FIFO is ignored and leaves the output as it was
	assign pop   = rd_en_i && !empty && !fifo_rst_i;

	// ************************************************
	// Pointers, occupancy and overflow
	// ************************************************
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			overflow_o <= 1'b0;
		end
		else if (fifo_rst_i)
		begin
			// Sequencer reset holds the FIFO empty and clears the flag
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			overflow_o <= 1'b0;
		end
		else
		begin
			// Depth is a power of two, so the pointers wrap on their own
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			// Sticky until the sequencer resets this group
			if (wr_en_i && full)
				overflow_o <= 1'b1;
		end
	end

	// Storage and registered read port
	always_ff @(posedge pll_afi_clk)
	begin
		if (push)
			mem[wr_ptr] <= wr_data_i;
		if (pop)
			rd_data_o <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

//--- hdl/rdp_oct_ctrl.sv
// ************************************************
// OCT control
// Keeps on-die termination forced off except in a
// window around each read burst
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module rdp_oct_ctrl (
	input  wire                     pll_afi_clk,
	input  wire                     reset_n_afi_clk,
	input  wire                     rdata_en_full_i,
	output rdp_phy_pkg::afi_phase_t force_oct_off_o
);

	import rdp_phy_pkg::*;
	import rdp_cfg_pkg::*;

	// History of the full read enable, bit j-1 holds the value j edges back
	logic [OCT_OFF_DELAY-1:0] en_r;
	// Same history with the live enable at index 0
	logic [OCT_OFF_DELAY:0]   en_hist;
	logic                     oct_off_r;

	assign en_hist = {en_r, rdata_en_full_i};

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_r      <= '0;
			oct_off_r <= 1'b0;
		end
		else
		begin
			en_r      <= en_hist[OCT_OFF_DELAY-1:0];
			// Termination is enabled while any read sits inside the window
			oct_off_r <= ~(|en_hist[OCT_OFF_DELAY:OCT_ON_DELAY]);
		end
	end

	// Both DQS lanes follow the same window
	assign force_oct_off_o = {AFI_RATE_RATIO{oct_off_r}};

endmodule

`default_nettype wire

//--- hdl/rdp_top.sv
// ************************************************
// Read datapath top level
// Per-group read FIFOs, latency shifter, OCT control
// and the register block, with data reordering
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module rdp_top (
	input  wire                            pll_afi_clk,
	input  wire                            reset_n_afi_clk,
	input  wire rdp_cfg_pkg::apb_req_t     apb_req_i,
	output wire rdp_cfg_pkg::apb_rsp_t     apb_rsp_o,
	input  wire rdp_phy_pkg::afi_rd_req_t  afi_rd_req_i,
	input  wire rdp_phy_pkg::afi_data_t    cap_data_i,
	input  wire rdp_phy_pkg::group_mask_t  cap_valid_i,
	output wire rdp_phy_pkg::afi_data_t    afi_rdata_o,
	output wire rdp_phy_pkg::afi_phase_t   afi_rdata_valid_o,
	output wire rdp_phy_pkg::afi_data_t    seq_rdata_o,
	output wire rdp_phy_pkg::afi_phase_t   force_oct_off_o
);

	import rdp_phy_pkg::*;
	import rdp_cfg_pkg::*;

	latency_t    latency;
	group_mask_t fifo_rst;
	group_mask_t overflow;
	logic        read_enable;
	// Popped word of each group, time slot 0 in the low byte
	group_data_t fifo_q [NUM_DQS_GROUPS];

	// ************************************************
	// Control blocks
	// ************************************************
	rdp_seq_regs u_seq_regs (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.apb_req_i       (apb_req_i),
		.apb_rsp_o       (apb_rsp_o),
		.overflow_i      (overflow),
		.latency_o       (latency),
		.fifo_rst_o      (fifo_rst)
	);

	// One read enable pops every group together
	rdp_latency_shifter u_latency_shifter (
		.pll_afi_clk       (pll_afi_clk),
		.reset_n_afi_clk   (reset_n_afi_clk),
		.afi_rd_req_i      (afi_rd_req_i),
		.latency_i         (latency),
		.read_enable_o     (read_enable),
		.afi_rdata_valid_o (afi_rdata_valid_o)
	);

	rdp_oct_ctrl u_oct_ctrl (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_full_i (afi_rd_req_i.rdata_en_full[0]),
		.force_oct_off_o (force_oct_off_o)
	);

	// ************************************************
	// Read FIFOs and data reordering
	// ************************************************
	for (genvar g = 0; g < NUM_DQS_GROUPS; g++)
	begin : g_group
		// Capture bus is group major, one 32-bit word per group
		rdp_read_fifo u_read_fifo (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.fifo_rst_i      (fifo_rst[g]),
			.wr_en_i         (cap_valid_i[g]),
			.wr_data_i       (cap_data_i[GROUP_DATA_WIDTH*g +: GROUP_DATA_WIDTH]),
			.rd_en_i         (read_enable),
			.rd_data_o       (fifo_q[g]),
			.overflow_o      (overflow[g])
		);

		// Sequencer wants group major order, which is the FIFO order already
		assign seq_rdata_o[GROUP_DATA_WIDTH*g +: GROUP_DATA_WIDTH] = fifo_q[g];

		// AFI wants time slot major order, groups interleaved within each slot
		for (genvar t = 0; t < NUM_TIMESLOTS; t++)
		begin : g_slot
			dq_group_t beat;

			assign beat = fifo_q[g][DQ_GROUP_WIDTH*t +: DQ_GROUP_WIDTH];
			assign afi_rdata_o[MEM_DQ_WIDTH*t + DQ_GROUP_WIDTH*g +: DQ_GROUP_WIDTH] = beat;
		end
	end

endmodule

`default_nettype wire

//--- tests/rdp_properties.sv
// **************************************************
// Read datapath properties
// APB ready, read valid phases and FIFO pops
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module rdp_properties (
	input wire                           pll_afi_clk,
	input wire                           reset_n_afi_clk,
	input wire rdp_cfg_pkg::apb_req_t    apb_req_i,
	input wire rdp_cfg_pkg::apb_rsp_t    apb_rsp_i,
	input wire rdp_phy_pkg::afi_phase_t  afi_rdata_valid_i,
	input wire                           read_enable_i,
	input wire rdp_phy_pkg::group_mask_t fifo_rst_i,
	input wire rdp_phy_pkg::fifo_cnt_t   fifo_cnt0_i,
	input wire rdp_phy_pkg::fifo_cnt_t   fifo_cnt1_i
);

	// The slave has no wait states, every access phase completes at once
	apb_ready_in_access: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		apb_req_i.psel && apb_req_i.penable |-> apb_rsp_i.pready)
		else $error("pready low in an APB access phase");

	// Half rate valid is the same in both phases and follows the pop by one cycle
	valid_timing: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid_i[0] == afi_rdata_valid_i[1] &&
		afi_rdata_valid_i[0] == $past(read_enable_i))
		else $error("afi_rdata_valid phases differ or do not follow the FIFO pop");

	// A delayed read enable must always find a word in each group
	no_pop_empty_g0: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		read_enable_i && !fifo_rst_i[0] |-> fifo_cnt0_i != '0)
		else $error("read FIFO of group 0 popped while empty");

	no_pop_empty_g1: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		read_enable_i && !fifo_rst_i[1] |-> fifo_cnt1_i != '0)
		else $error("read FIFO of group 1 popped while empty");

endmodule

bind rdp_top rdp_properties u_properties (
	.pll_afi_clk       (pll_afi_clk),
	.reset_n_afi_clk   (reset_n_afi_clk),
	.apb_req_i         (apb_req_i),
	.apb_rsp_i         (apb_rsp_o),
	.afi_rdata_valid_i (afi_rdata_valid_o),
	.read_enable_i     (read_enable),
	.fifo_rst_i        (fifo_rst),
	.fifo_cnt0_i       (g_group[0].u_read_fifo.count),
	.fifo_cnt1_i       (g_group[1].u_read_fifo.count)
);

`default_nettype wire

//--- tests/rdp_tb.sv
// **************************************************
// Read datapath testbench
// Drives APB, capture and read requests into the
// read datapath and checks it against a cycle model
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module rdp_tb;

	import rdp_phy_pkg::*;
	import rdp_cfg_pkg::*;

	localparam int CLK_PERIOD = 20;
	// Upper bounds in cycles, a latency run is capture, six reads, drain and idle
	localparam int REG_TEST_CYCLES = 100;
	localparam int LAT_TEST_CYCLES = 200;
	localparam int TIMEOUT_CYCLES  = REG_TEST_CYCLES + 6 * LAT_TEST_CYCLES + 400;

	logic        pll_afi_clk;
	logic        reset_n_afi_clk;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	afi_rd_req_t afi_rd_req;
	afi_data_t   cap_data;
	group_mask_t cap_valid;
	afi_data_t   afi_rdata;
	afi_phase_t  afi_rdata_valid;
	afi_data_t   seq_rdata;
	afi_phase_t  force_oct_off;

	// Cycle model, one queue per DQS group
	group_data_t                 model_q [NUM_DQS_GROUPS][$];
	// Last popped word of every group, group major like the sequencer bus
	afi_data_t                   exp_words;
	logic [MAX_READ_LATENCY-1:0] valid_hist = '0;
	logic [MAX_READ_LATENCY-1:0] full_hist = '0;
	logic                        exp_valid = 1'b0;
	logic                        exp_oct = 1'b0;
	latency_t                    lat_model = LAT_RESET;
	group_mask_t                 rst_model = '0;
	group_mask_t                 ovf_model = '0;
	logic [31:0]                 lfsr;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_errors = 0;
	int reads_issued = 0;
	int reads_seen = 0;
	int oct_low_cycles = 0;
	string test_name = "reset";

	rdp_top dut (
		.pll_afi_clk       (pll_afi_clk),
		.reset_n_afi_clk   (reset_n_afi_clk),
		.apb_req_i         (apb_req),
		.apb_rsp_o         (apb_rsp),
		.afi_rd_req_i      (afi_rd_req),
		.cap_data_i        (cap_data),
		.cap_valid_i       (cap_valid),
		.afi_rdata_o       (afi_rdata),
		.afi_rdata_valid_o (afi_rdata_valid),
		.seq_rdata_o       (seq_rdata),
		.force_oct_off_o   (force_oct_off)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #(CLK_PERIOD / 2) pll_afi_clk = ~pll_afi_clk;
	end

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic random_bits(input int nbits, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < nbits; i++)
		begin
			lfsr  = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	// Beat t of group g moves from offset 32g+8t to offset 16t+8g
	function automatic afi_data_t slot_major_order(input afi_data_t group_major);
		afi_data_t r;
		for (int g = 0; g < NUM_DQS_GROUPS; g++)
			for (int t = 0; t < NUM_TIMESLOTS; t++)
				r[MEM_DQ_WIDTH*t + DQ_GROUP_WIDTH*g +: DQ_GROUP_WIDTH] =
					group_major[GROUP_DATA_WIDTH*g + DQ_GROUP_WIDTH*t +: DQ_GROUP_WIDTH];
		return r;
	endfunction

	// Termination is on while a read sampled 3 to 8 edges back is in the window
	function automatic logic oct_window_open(input logic [MAX_READ_LATENCY-1:0] hist);
		logic open;
		open = 1'b0;
		for (int k = OCT_ON_DELAY; k <= OCT_OFF_DELAY; k++)
			open |= hist[k];
		return open;
	endfunction

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, expected,
				actual);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR in %s: %s", test_name, msg);
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = errors;
	endtask

	task automatic finish_test();
		tests++;
		$display("test %-16s %s, %0d errors", test_name,
			(errors == test_errors) ? "ok" : "failed", errors - test_errors);
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge pll_afi_clk);
	endtask

	// **************************************************
	// APB master, setup then access, waits for pready
	// **************************************************
	task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
		output apb_data_t rdata, output logic slverr);
		int waited;
		@(posedge pll_afi_clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge pll_afi_clk);
		apb_req.penable <= 1'b1;
		@(negedge pll_afi_clk);
		waited = 0;
		while (!apb_rsp.pready && waited < 8)
		begin
			@(negedge pll_afi_clk);
			waited++;
		end
		if (!apb_rsp.pready)
			report_error($sformatf("APB access to 0x%h never got pready", addr));
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(posedge pll_afi_clk);
		apb_req <= '0;
	endtask

	// Pushes n random words into every group of the mask, strobes are random too
	task automatic push_words(input group_mask_t mask, input int n);
		int          pushed [NUM_DQS_GROUPS];
		int          remaining;
		logic [31:0] strobe;
		logic [31:0] word;
		group_mask_t valid;
		afi_data_t   data;
		remaining = n * $countones(mask);
		for (int g = 0; g < NUM_DQS_GROUPS; g++)
			pushed[g] = 0;
		while (remaining > 0)
		begin
			random_bits(NUM_DQS_GROUPS, strobe);
			valid = '0;
			data  = '0;
			for (int g = 0; g < NUM_DQS_GROUPS; g++)
			begin
				if (mask[g] && strobe[g] && pushed[g] < n)
				begin
					random_bits(GROUP_DATA_WIDTH, word);
					valid[g] = 1'b1;
					data[GROUP_DATA_WIDTH*g +: GROUP_DATA_WIDTH] = word;
					pushed[g]++;
					remaining--;
				end
			end
			@(posedge pll_afi_clk);
			cap_valid <= valid;
			cap_data  <= data;
		end
		@(posedge pll_afi_clk);
		cap_valid <= '0;
	endtask

	// Back to back read pulses, all enable bits high together
	task automatic issue_reads(input int n);
		repeat (n)
		begin
			@(posedge pll_afi_clk);
			afi_rd_req <= '1;
			reads_issued++;
		end
		@(posedge pll_afi_clk);
		afi_rd_req <= '0;
	endtask

	task automatic wait_reads_done();
		int waited;
		waited = 0;
		while (reads_seen < reads_issued && waited < 4 * MAX_READ_LATENCY)
		begin
			@(posedge pll_afi_clk);
			waited++;
		end
		if (reads_seen < reads_issued)
			report_error($sformatf("only %0d of %0d read valids arrived", reads_seen,
				reads_issued));
	endtask

	task automatic latency_test(input int lat);
		apb_data_t rd;
		logic      err;
		start_test($sformatf("latency_%0d", lat));
		apb_access(1'b1, ADDR_LAT, apb_data_t'(lat), rd, err);
		lat_model = latency_t'(lat);
		push_words(2'b11, 6);
		issue_reads(3);
		idle(2);
		issue_reads(2);
		idle(3);
		issue_reads(1);
		wait_reads_done();
		// Let the shift registers drain before the latency can change
		idle(MAX_READ_LATENCY + 4);
		finish_test();
	endtask

	// **************************************************
	// Reference model, updated on every rising edge
	// **************************************************
	always @(posedge pll_afi_clk)
	begin : model
		logic pop;
		logic was_full;
		if (!reset_n_afi_clk)
		begin
			valid_hist = '0;
			full_hist  = '0;
			exp_valid  = 1'b0;
			exp_oct    = 1'b0;
			ovf_model  = '0;
			for (int g = 0; g < NUM_DQS_GROUPS; g++)
				model_q[g].delete();
		end
		else
		begin
			// Before the shift, index L holds the enable sampled L+1 edges ago
			exp_valid  = valid_hist[lat_model];
			pop        = full_hist[lat_model];
			// After the shift, index k holds the enable sampled k edges ago
			valid_hist = {valid_hist[MAX_READ_LATENCY-2:0], afi_rd_req.rdata_en[0]};
			full_hist  = {full_hist[MAX_READ_LATENCY-2:0], afi_rd_req.rdata_en_full[0]};
			exp_oct    = !oct_window_open(full_hist);
			for (int g = 0; g < NUM_DQS_GROUPS; g++)
			begin
				if (rst_model[g])
				begin
					model_q[g].delete();
					ovf_model[g] = 1'b0;
				end
				else
				begin
					// Full is judged before the pop, so a word on a full FIFO is lost
					was_full = (model_q[g].size() == READ_FIFO_DEPTH);
					if (pop && model_q[g].size() > 0)
						exp_words[GROUP_DATA_WIDTH*g +: GROUP_DATA_WIDTH] = model_q[g].pop_front();
					if (cap_valid[g] && was_full)
						ovf_model[g] = 1'b1;
					else if (cap_valid[g])
						model_q[g].push_back(cap_data[GROUP_DATA_WIDTH*g +: GROUP_DATA_WIDTH]);
				end
			end
		end
	end

	// Outputs are compared on the falling edge, where they are stable
	always @(negedge pll_afi_clk)
	begin
		if (reset_n_afi_clk)
		begin
			check_value("afi_rdata_valid", 64'({AFI_RATE_RATIO{exp_valid}}), 64'(afi_rdata_valid));
			check_value("force_oct_off", 64'({AFI_RATE_RATIO{exp_oct}}), 64'(force_oct_off));
			if (exp_valid)
			begin
				check_value("afi_rdata", slot_major_order(exp_words), afi_rdata);
				check_value("seq_rdata", exp_words, seq_rdata);
			end
			if (afi_rdata_valid[0])
				reads_seen++;
			if (!force_oct_off[0])
				oct_low_cycles++;
		end
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge pll_afi_clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		apb_data_t rd;
		logic      err;
		reset_n_afi_clk = 1'b0;
		apb_req         = '0;
		afi_rd_req      = '0;
		cap_data        = '0;
		cap_valid       = '0;
		lfsr            = 32'd66667;
		repeat (2) @(posedge pll_afi_clk);
		reset_n_afi_clk <= 1'b1;
		@(posedge pll_afi_clk);

		start_test("register_access");
		apb_access(1'b0, ADDR_LAT, '0, rd, err);
		check_value("LAT reset value", 64'(LAT_RESET), 64'(rd));
		apb_access(1'b1, ADDR_LAT, 32'd9, rd, err);
		check_value("LAT write pslverr", 64'(0), 64'(err));
		apb_access(1'b0, ADDR_LAT, '0, rd, err);
		check_value("LAT readback", 64'(9), 64'(rd));
		// Zero latency is stored as one
		apb_access(1'b1, ADDR_LAT, '0, rd, err);
		apb_access(1'b0, ADDR_LAT, '0, rd, err);
		check_value("LAT zero write", 64'(1), 64'(rd));
		apb_access(1'b1, ADDR_FIFO_RST, 32'd3, rd, err);
		apb_access(1'b0, ADDR_FIFO_RST, '0, rd, err);
		check_value("FIFO_RST readback", 64'(3), 64'(rd));
		apb_access(1'b1, ADDR_FIFO_RST, '0, rd, err);
		apb_access(1'b0, 4'hC, '0, rd, err);
		check_value("unmapped pslverr", 64'(1), 64'(err));
		apb_access(1'b1, ADDR_STATUS, 32'd3, rd, err);
		check_value("STATUS write pslverr", 64'(1), 64'(err));
		finish_test();

		latency_test(4);

		// Groups fill at different times, so their words differ in order
		start_test("seq_order");
		push_words(2'b01, 3);
		push_words(2'b10, 5);
		push_words(2'b01, 2);
		issue_reads(5);
		wait_reads_done();
		idle(MAX_READ_LATENCY + 4);
		finish_test();

		latency_test(1);
		latency_test(15);

		start_test("oct_window");
		push_words(2'b11, 1);
		oct_low_cycles = 0;
		issue_reads(1);
		wait_reads_done();
		idle(OCT_OFF_DELAY + 4);
		check_value("OCT low cycles", 64'(OCT_OFF_DELAY - OCT_ON_DELAY + 1), 64'(oct_low_cycles));
		finish_test();

		// Nine words into group 0 overflow its 8 entries
		start_test("overflow_reset");
		push_words(2'b01, READ_FIFO_DEPTH + 1);
		apb_access(1'b0, ADDR_STATUS, '0, rd, err);
		check_value("STATUS after overflow", 64'(ovf_model), 64'(rd));
		apb_access(1'b1, ADDR_FIFO_RST, 32'd1, rd, err);
		rst_model = 2'b01;
		idle(2);
		apb_access(1'b1, ADDR_FIFO_RST, '0, rd, err);
		rst_model = 2'b00;
		apb_access(1'b0, ADDR_STATUS, '0, rd, err);
		check_value("STATUS after FIFO reset", 64'(0), 64'(rd));
		// A fresh word must come out first if the FIFO was emptied
		push_words(2'b11, 1);
		issue_reads(1);
		wait_reads_done();
		idle(MAX_READ_LATENCY + 4);
		finish_test();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
hdl/rdp_phy_pkg.sv
hdl/rdp_cfg_pkg.sv
hdl/rdp_seq_regs.sv
hdl/rdp_latency_shifter.sv
hdl/rdp_read_fifo.sv
hdl/rdp_oct_ctrl.sv
hdl/rdp_top.sv
tests/rdp_properties.sv
tests/rdp_tb.sv

//--- Makefile
# Verilator build and run of the read datapath testbench

VERILATOR ?= verilator
TOP       ?= rdp_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, a run that stops early has no pass line
run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
